// ==== list.f ====
+incdir+verilog
verilog/cpu_pkg.sv
verilog/control_unit.sv
verilog/register_file.sv
verilog/forward_unit.sv
verilog/alu.sv
verilog/data_memory.sv
verilog/cpu_core.sv
verif/clock_gen.sv
verif/cpu_properties.sv
verif/cpu_tb.sv

// ==== verif/cpu_tb.sv ====
// Testbench for the five-stage pipeline core
// Builds a random program, serves it on the external fetch port and
// checks write-back, overflow and syscall against an in-order model
`include "cpu_params.svh"

module cpu_tb
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROG_LEN      = 200;
    localparam int CLK_PERIOD_NS = 100;
    localparam int RESET_CYCLES  = 8;
    // Four stages to drain plus slack
    localparam int RUN_CYCLES    = PROG_LEN + 6;
    localparam int WATCHDOG_NS   = (PROG_LEN + 20) * CLK_PERIOD_NS;

    logic      clk;
    logic      rst;
    word_t     imem_addr;
    word_t     imem_data;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      overflow;
    logic      syscall;

    integer    seed;
    int        check_count;
    int        error_count;
    int        n_writes;
    int        n_loads;
    int        n_overflows;
    int        n_syscalls;

    // Program image and generator state
    word_t     prog_words [PROG_LEN];
    logic      stored_words [`CPU_DMEM_WORDS];
    // Architectural state of the model
    word_t     model_regs [`CPU_REG_COUNT];
    word_t     model_mem [`CPU_DMEM_WORDS];
    // Expected effects, indexed by program position
    logic      exp_wen [PROG_LEN];
    reg_addr_t exp_waddr [PROG_LEN];
    word_t     exp_wdata [PROG_LEN];
    logic      exp_ovf [PROG_LEN];
    logic      exp_sys [PROG_LEN];

    clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) i_clock_gen (.clk(clk));

    cpu_core i_dut (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .overflow  (overflow),
        .syscall   (syscall)
    );

    bind cpu_core cpu_properties i_properties (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .syscall   (syscall)
    );

    // ========================================
    // Program generation
    // ========================================

    function automatic word_t encode_rtype(input reg_addr_t rs, input reg_addr_t rt,
                                           input reg_addr_t rd, input logic [4:0] shamt,
                                           input logic [5:0] funct);
        return {`CPU_OP_RTYPE, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t encode_itype(input logic [5:0] opcode, input reg_addr_t rs,
                                           input reg_addr_t rt, input imm_t imm);
        return {opcode, rs, rt, imm};
    endfunction

    function automatic int unsigned random_below(input int unsigned limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    // Eight ALU functions picked by a 3-bit selector
    function automatic logic [5:0] rtype_funct(input int unsigned sel);
        case (sel)
            0:       return `CPU_FN_ADD;
            1:       return `CPU_FN_SUB;
            2:       return `CPU_FN_AND;
            3:       return `CPU_FN_OR;
            4:       return `CPU_FN_XOR;
            5:       return `CPU_FN_SLT;
            6:       return `CPU_FN_SLL;
            default: return `CPU_FN_SRL;
        endcase
    endfunction

    // True when the word takes register r as a source operand
    function automatic logic reads_register(input word_t inst, input reg_addr_t r);
        logic [5:0] opcode;
        logic [5:0] funct;
        logic       rs_hit;
        logic       rt_hit;
        opcode = inst[31:26];
        funct  = inst[5:0];
        rs_hit = (inst[25:21] == r);
        rt_hit = (inst[20:16] == r);
        case (opcode)
            `CPU_OP_RTYPE: begin
                if (funct == `CPU_FN_SYSCALL) begin
                    return 1'b0;
                end
                // Shifts only read rt
                if ((funct == `CPU_FN_SLL) || (funct == `CPU_FN_SRL)) begin
                    return rt_hit;
                end
                return rs_hit || rt_hit;
            end
            `CPU_OP_SW:  return rs_hit || rt_hit;
            `CPU_OP_LUI: return 1'b0;
            default:     return rs_hit;
        endcase
    endfunction

    // One random instruction over r0..r7
    function automatic word_t random_instruction();
        int unsigned pick;
        int unsigned slot;
        int unsigned i;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        imm_t        imm;
        pick = random_below(32);
        rs   = reg_addr_t'(random_below(8));
        rt   = reg_addr_t'(random_below(8));
        rd   = reg_addr_t'(random_below(8));
        imm  = imm_t'(random_below(65536));
        slot = random_below(`CPU_DMEM_WORDS);
        // Load from the next word already stored or fall back to a store
        if ((pick >= 27) && (pick <= 29)) begin
            for (i = 0; i < `CPU_DMEM_WORDS; i++) begin
                if (stored_words[(slot + i) % `CPU_DMEM_WORDS]) begin
                    return encode_itype(`CPU_OP_LW, '0, rt,
                                        imm_t'(((slot + i) % `CPU_DMEM_WORDS) * 4));
                end
            end
            pick = 23;
        end
        if (pick < 16) begin
            return encode_rtype(rs, rt, rd, imm[10:6], rtype_funct(pick % 8));
        end else if (pick < 19) begin
            return encode_itype(`CPU_OP_ADDI, rs, rt, imm);
        end else if (pick == 19) begin
            return encode_itype(`CPU_OP_ANDI, rs, rt, imm);
        end else if (pick == 20) begin
            return encode_itype(`CPU_OP_ORI, rs, rt, imm);
        end else if (pick < 23) begin
            return encode_itype(`CPU_OP_LUI, '0, rt, imm);
        end else if (pick < 27) begin
            // Stores always based on r0
            return encode_itype(`CPU_OP_SW, '0, rt, imm_t'(slot * 4));
        end else if (pick == 30) begin
            // Random rd in the code field must still write nothing
            return encode_rtype('0, '0, rd, '0, `CPU_FN_SYSCALL);
        end
        return encode_itype(`CPU_OP_ADDI, rs, rt, imm);
    endfunction

    task automatic build_program();
        reg_addr_t load_dest;
        word_t     inst;
        int        k;
        for (k = 0; k < `CPU_DMEM_WORDS; k++) begin
            stored_words[k] = 1'b0;
        end
        load_dest = '0;
        for (k = 0; k < PROG_LEN; k++) begin
            // Keep a load's destination out of the next instruction's sources
            do begin
                inst = random_instruction();
            end while ((load_dest != '0) && reads_register(inst, load_dest));
            if (inst[31:26] == `CPU_OP_SW) begin
                stored_words[inst[7:2]] = 1'b1;
            end
            load_dest     = (inst[31:26] == `CPU_OP_LW) ? inst[20:16] : '0;
            prog_words[k] = inst;
        end
    endtask

    // ========================================
    // Reference model
    // ========================================

    // Signed overflow via one extra sign bit
    function automatic logic signed_overflow(input word_t x, input word_t y,
                                             input logic subtract);
        logic [32:0] wide;
        if (subtract) begin
            wide = {x[31], x} - {y[31], y};
        end else begin
            wide = {x[31], x} + {y[31], y};
        end
        return wide[32] != wide[31];
    endfunction

    task automatic run_model();
        word_t      inst;
        logic [5:0] funct;
        reg_addr_t  dest;
        word_t      a;
        word_t      b;
        word_t      sext;
        word_t      zext;
        word_t      result;
        word_t      addr;
        logic       wr;
        logic       ovf;
        logic       sys;
        int         k;
        for (k = 0; k < `CPU_REG_COUNT; k++) begin
            model_regs[k] = '0;
        end
        for (k = 0; k < PROG_LEN; k++) begin
            inst   = prog_words[k];
            funct  = inst[5:0];
            a      = model_regs[inst[25:21]];
            b      = model_regs[inst[20:16]];
            sext   = {{16{inst[15]}}, inst[15:0]};
            zext   = {16'h0000, inst[15:0]};
            dest   = inst[20:16];
            result = '0;
            wr     = 1'b1;
            ovf    = 1'b0;
            sys    = 1'b0;
            case (inst[31:26])
                `CPU_OP_RTYPE: begin
                    dest = inst[15:11];
                    case (funct)
                        `CPU_FN_ADD: begin
                            result = a + b;
                            ovf    = signed_overflow(a, b, 1'b0);
                        end
                        `CPU_FN_SUB: begin
                            result = a - b;
                            ovf    = signed_overflow(a, b, 1'b1);
                        end
                        `CPU_FN_AND: result = a & b;
                        `CPU_FN_OR:  result = a | b;
                        `CPU_FN_XOR: result = a ^ b;
                        `CPU_FN_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        `CPU_FN_SLL: result = b << inst[10:6];
                        `CPU_FN_SRL: result = b >> inst[10:6];
                        `CPU_FN_SYSCALL: begin
                            wr  = 1'b0;
                            sys = 1'b1;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                `CPU_OP_ADDI: begin
                    result = a + sext;
                    ovf    = signed_overflow(a, sext, 1'b0);
                end
                `CPU_OP_ANDI: result = a & zext;
                `CPU_OP_ORI:  result = a | zext;
                `CPU_OP_LUI:  result = {inst[15:0], 16'h0000};
                `CPU_OP_LW: begin
                    addr   = a + sext;
                    result = model_mem[addr[7:2]];
                end
                `CPU_OP_SW: begin
                    addr = a + sext;
                    model_mem[addr[7:2]] = b;
                    wr   = 1'b0;
                end
                default: wr = 1'b0;
            endcase
            // r0 stays zero and shows no write
            if (dest == '0) begin
                wr = 1'b0;
            end
            if (wr) begin
                model_regs[dest] = result;
            end
            exp_wen[k]   = wr;
            exp_waddr[k] = dest;
            exp_wdata[k] = result;
            exp_ovf[k]   = ovf;
            exp_sys[k]   = sys;
            n_writes    += wr;
            n_loads     += (wr && (inst[31:26] == `CPU_OP_LW));
            n_overflows += ovf;
            n_syscalls  += sys;
        end
    endtask

    // ========================================
    // Checks and stimulus
    // ========================================

    task automatic compare_word(input string name, input word_t got, input word_t expected,
                                input int cycle);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail %s: got %0h, expected %0h, cycle %0d", name, got, expected, cycle);
        end
    endtask

    // Write-back lags fetch by 4 cycles and overflow by 2
    task automatic check_step(input int n);
        logic e_wen;
        logic e_sys;
        logic e_ovf;
        int   wb_k;
        wb_k  = n - 4;
        e_wen = 1'b0;
        e_sys = 1'b0;
        e_ovf = 1'b0;
        if ((wb_k >= 0) && (wb_k < PROG_LEN)) begin
            e_wen = exp_wen[wb_k];
            e_sys = exp_sys[wb_k];
        end
        if ((n >= 2) && (n - 2 < PROG_LEN)) begin
            e_ovf = exp_ovf[n - 2];
        end
        compare_word("imem_addr", imem_addr, word_t'(n * 4), n);
        compare_word("wb_en", wb_en, e_wen, n);
        if (e_wen) begin
            compare_word("wb_addr", wb_addr, exp_waddr[wb_k], n);
            compare_word("wb_data", wb_data, exp_wdata[wb_k], n);
        end
        compare_word("syscall", syscall, e_sys, n);
        compare_word("overflow", overflow, e_ovf, n);
    endtask

    // Zero past the end of the program decodes as a no-op
    task automatic drive_fetch();
        word_t index;
        index = imem_addr >> 2;
        if (index < PROG_LEN) begin
            imem_data = prog_words[index];
        end else begin
            imem_data = '0;
        end
    endtask

    initial begin
        int n;
        int base_checks;
        int base_errors;
        rst         = 1'b1;
        imem_data   = '0;
        seed        = 32'h8e7a_dcc5;
        check_count = 0;
        error_count = 0;
        n_writes    = 0;
        n_loads     = 0;
        n_overflows = 0;
        n_syscalls  = 0;
        build_program();
        run_model();

        // Outputs idle and PC parked while reset is held
        for (n = 0; n < RESET_CYCLES; n++) begin
            @(negedge clk);
            compare_word("imem_addr", imem_addr, '0, n);
            compare_word("wb_en", wb_en, '0, n);
            compare_word("syscall", syscall, '0, n);
            compare_word("overflow", overflow, '0, n);
        end
        $display("Test reset: %0d checks, %0d errors", check_count, error_count);
        base_checks = check_count;
        base_errors = error_count;
        rst = 1'b0;

        // Release and first fetch share the same falling edge
        for (n = 0; n < RUN_CYCLES; n++) begin
            if (n > 0) begin
                @(negedge clk);
            end
            check_step(n);
            drive_fetch();
        end
        $display("Test program: %0d checks, %0d errors (%0d wr, %0d lw, %0d ovf, %0d sys)",
                 check_count - base_checks, error_count - base_errors,
                 n_writes, n_loads, n_overflows, n_syscalls);
        $display("Summary: 2 tests, %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog sized from program length plus reset and drain
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: program run did not complete within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== verif/cpu_properties.sv ====
// Concurrent checks on the ports of the pipeline core
// Bound onto cpu_core from the testbench
module cpu_properties
    import cpu_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input word_t     imem_addr,
    input logic      wb_en,
    input reg_addr_t wb_addr,
    input logic      syscall
);

    timeunit 1ns;
    timeprecision 100ps;

    // Fetch address walks forward one word per cycle
    pc_step: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (imem_addr == $past(imem_addr) + 32'd4))
        else $error("imem_addr did not advance by one word");

    // r0 never shows up as a write-back target
    wb_nonzero: assert property (@(posedge clk) disable iff (rst)
        wb_en |-> (wb_addr != '0))
        else $error("wb_en asserted for register 0");

    // A syscall in write-back carries no register write
    sys_no_write: assert property (@(posedge clk) disable iff (rst)
        !(syscall && wb_en))
        else $error("syscall and wb_en high in the same cycle");

endmodule

// ==== verif/clock_gen.sv ====
// Free-running testbench clock that starts low
// Period in ns set by parameter
module clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    // Half period low, half period high
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

// ==== verilog/cpu_core.sv ====
// Five-stage in-order integer pipeline, top level
// Instruction memory is external and imem_data holds the word at imem_addr
// Write-back port, overflow and syscall are exposed for observation
`include "cpu_params.svh"

module cpu_core
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      overflow,
    output logic      syscall
);

    // Fetch / decode
    word_t     pc;
    word_t     id_inst;
    word_t     id_rs_value, id_rt_value, id_imm_word;
    alu_op_e   id_alu_op;
    reg_addr_t id_waddr;
    logic      id_a_from_rt, id_b_from_imm, id_wen, id_wb_from_mem;
    logic      id_dm_wen, id_syscall, id_ovf_check;
    // Execute
    reg_addr_t ex_rs, ex_rt, ex_waddr;
    word_t     ex_rs_value, ex_rt_value, ex_imm_word;
    alu_op_e   ex_alu_op;
    logic      ex_a_from_rt, ex_b_from_imm, ex_wen, ex_wb_from_mem;
    logic      ex_dm_wen, ex_syscall, ex_ovf_check;
    word_t     ex_a_value, ex_b_value, alu_a, alu_b, alu_result;
    // Memory
    word_t     mem_alu_result, mem_store_data, mem_rdata;
    reg_addr_t mem_waddr;
    logic      mem_wen, mem_wb_from_mem, mem_dm_wen, mem_syscall;
    // Write-back and buffer
    word_t     wb_alu_result, wb_mem_rdata, buf_data;
    logic      wb_from_mem, buf_wen;
    reg_addr_t buf_waddr;

    // ========================================
    // Fetch
    // ========================================

    // PC walks forward with no branches
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc      <= '0;
            id_inst <= '0;
        end else begin
            pc      <= pc + 'd4;
            id_inst <= imem_data;
        end
    end

    assign imem_addr = pc;

    // ========================================
    // Decode
    // ========================================

    control_unit i_control_unit (
        .inst        (id_inst),
        .alu_op      (id_alu_op),
        .a_from_rt   (id_a_from_rt),
        .b_from_imm  (id_b_from_imm),
        .imm_word    (id_imm_word),
        .rf_waddr    (id_waddr),
        .rf_wen      (id_wen),
        .wb_from_mem (id_wb_from_mem),
        .dm_wen      (id_dm_wen),
        .syscall     (id_syscall),
        .ovf_check   (id_ovf_check)
    );

    // Read ports take rs from bits 25..21 and rt from bits 20..16
    register_file i_register_file (
        .clk    (clk),
        .rst    (rst),
        .raddr0 (id_inst[25:21]),
        .raddr1 (id_inst[20:16]),
        .rdata0 (id_rs_value),
        .rdata1 (id_rt_value),
        .wen    (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

    // ID/EX register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_rs          <= '0;
            ex_rt          <= '0;
            ex_rs_value    <= '0;
            ex_rt_value    <= '0;
            ex_imm_word    <= '0;
            ex_alu_op      <= ALU_ADD;
            ex_a_from_rt   <= 1'b0;
            ex_b_from_imm  <= 1'b0;
            ex_waddr       <= '0;
            ex_wen         <= 1'b0;
            ex_wb_from_mem <= 1'b0;
            ex_dm_wen      <= 1'b0;
            ex_syscall     <= 1'b0;
            ex_ovf_check   <= 1'b0;
        end else begin
            ex_rs          <= id_inst[25:21];
            ex_rt          <= id_inst[20:16];
            ex_rs_value    <= id_rs_value;
            ex_rt_value    <= id_rt_value;
            ex_imm_word    <= id_imm_word;
            ex_alu_op      <= id_alu_op;
            ex_a_from_rt   <= id_a_from_rt;
            ex_b_from_imm  <= id_b_from_imm;
            ex_waddr       <= id_waddr;
            ex_wen         <= id_wen;
            ex_wb_from_mem <= id_wb_from_mem;
            ex_dm_wen      <= id_dm_wen;
            ex_syscall     <= id_syscall;
            ex_ovf_check   <= id_ovf_check;
        end
    end

    // ========================================
    // Execute
    // ========================================

    // Memory stage forwards the ALU result and has no load-use bypass
    forward_unit i_forward_unit (
        .rs        (ex_rs),
        .rt        (ex_rt),
        .rs_value  (ex_rs_value),
        .rt_value  (ex_rt_value),
        .mem_wen   (mem_wen),
        .wb_wen    (wb_en),
        .buf_wen   (buf_wen),
        .mem_waddr (mem_waddr),
        .wb_waddr  (wb_addr),
        .buf_waddr (buf_waddr),
        .mem_data  (mem_alu_result),
        .wb_data   (wb_data),
        .buf_data  (buf_data),
        .a_value   (ex_a_value),
        .b_value   (ex_b_value)
    );

    // Shifts take rt as a and immediates replace b
    assign alu_a = ex_a_from_rt ? ex_b_value : ex_a_value;
    assign alu_b = ex_b_from_imm ? ex_imm_word : ex_b_value;

    alu i_alu (
        .a         (alu_a),
        .b         (alu_b),
        .op        (ex_alu_op),
        .ovf_check (ex_ovf_check),
        .result    (alu_result),
        .overflow  (overflow)
    );

    // EX/MEM register with the forwarded rt as store data
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_alu_result  <= '0;
            mem_store_data  <= '0;
            mem_waddr       <= '0;
            mem_wen         <= 1'b0;
            mem_wb_from_mem <= 1'b0;
            mem_dm_wen      <= 1'b0;
            mem_syscall     <= 1'b0;
        end else begin
            mem_alu_result  <= alu_result;
            mem_store_data  <= ex_b_value;
            mem_waddr       <= ex_waddr;
            mem_wen         <= ex_wen;
            mem_wb_from_mem <= ex_wb_from_mem;
            mem_dm_wen      <= ex_dm_wen;
            mem_syscall     <= ex_syscall;
        end
    end

    // ========================================
    // Memory
    // ========================================

    // Word index from address bits 7..2
    data_memory i_data_memory (
        .clk   (clk),
        .wen   (mem_dm_wen),
        .index (mem_alu_result[`CPU_DMEM_INDEX_W+1:2]),
        .wdata (mem_store_data),
        .rdata (mem_rdata)
    );

    // MEM/WB register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_alu_result <= '0;
            wb_mem_rdata  <= '0;
            wb_addr       <= '0;
            wb_en         <= 1'b0;
            wb_from_mem   <= 1'b0;
            syscall       <= 1'b0;
        end else begin
            wb_alu_result <= mem_alu_result;
            wb_mem_rdata  <= mem_rdata;
            wb_addr       <= mem_waddr;
            wb_en         <= mem_wen;
            wb_from_mem   <= mem_wb_from_mem;
            syscall       <= mem_syscall;
        end
    end

    // ========================================
    // Write-back and buffer
    // ========================================

    assign wb_data = wb_from_mem ? wb_mem_rdata : wb_alu_result;

    // Covers the decode read that misses this cycle's write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            buf_wen   <= 1'b0;
            buf_waddr <= '0;
            buf_data  <= '0;
        end else begin
            buf_wen   <= wb_en;
            buf_waddr <= wb_addr;
            buf_data  <= wb_data;
        end
    end

endmodule

// ==== verilog/data_memory.sv ====
// Word-wide data memory of the memory stage
// Synchronous write, combinational read, contents not reset
`include "cpu_params.svh"

module data_memory
    import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        wen,
    input  dmem_index_t index,
    input  word_t       wdata,
    output word_t       rdata
);

    word_t mem [0:`CPU_DMEM_WORDS-1];

    // Store on rising edge
    always_ff @(posedge clk) begin
        if (wen) begin
            mem[index] <= wdata;
        end
    end

    // Load data available in the same cycle
    assign rdata = mem[index];

endmodule

// ==== verilog/alu.sv ====
// Integer ALU of the execute stage
// Overflow only reported when the decoder asks for a signed check
module alu
    import cpu_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    input  logic    ovf_check,
    output word_t   result,
    output logic    overflow
);

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed overflow from operand signs against result sign
    assign add_ovf = (a[$bits(word_t)-1] == b[$bits(word_t)-1])
                   && (sum[$bits(word_t)-1] != a[$bits(word_t)-1]);
    assign sub_ovf = (a[$bits(word_t)-1] != b[$bits(word_t)-1])
                   && (diff[$bits(word_t)-1] != a[$bits(word_t)-1]);

    always_comb begin
        case (op)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{($bits(word_t)-1){1'b0}}, ($signed(a) < $signed(b))};
            // Shift amount is b[4:0]
            ALU_SLL: result = a << b[4:0];
            ALU_SRL: result = a >> b[4:0];
            ALU_LUI: result = {b[15:0], 16'b0};
            default: result = sum;
        endcase
    end

    assign overflow = ovf_check
                    && (((op == ALU_ADD) && add_ovf) || ((op == ALU_SUB) && sub_ovf));

endmodule

// ==== verilog/forward_unit.sv ====
// Operand bypass for the execute stage
// Newest matching writer wins in the order memory, write-back, buffer
module forward_unit
    import cpu_pkg::*;
(
    input  reg_addr_t rs,
    input  reg_addr_t rt,
    input  word_t     rs_value,
    input  word_t     rt_value,
    input  logic      mem_wen,
    input  logic      wb_wen,
    input  logic      buf_wen,
    input  reg_addr_t mem_waddr,
    input  reg_addr_t wb_waddr,
    input  reg_addr_t buf_waddr,
    input  word_t     mem_data,
    input  word_t     wb_data,
    input  word_t     buf_data,
    output word_t     a_value,
    output word_t     b_value
);

    // Same priority chain for both operands
    function automatic word_t bypass(input reg_addr_t src, input word_t rf_value);
        if (mem_wen && (mem_waddr == src)) begin
            return mem_data;
        end else if (wb_wen && (wb_waddr == src)) begin
            return wb_data;
        end else if (buf_wen && (buf_waddr == src)) begin
            return buf_data;
        end
        return rf_value;
    endfunction

    // Upstream writers never target r0
    always_comb begin
        a_value = bypass(rs, rs_value);
        b_value = bypass(rt, rt_value);
    end

endmodule

// ==== verilog/register_file.sv ====
// General purpose register file with two read ports and one write port
// Read in decode, written from the write-back stage
`include "cpu_params.svh"

module register_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t raddr0,
    input  reg_addr_t raddr1,
    output word_t     rdata0,
    output word_t     rdata1,
    input  logic      wen,
    input  reg_addr_t waddr,
    input  word_t     wdata
);

    // Storage for r1..r31 only
    word_t regs [1:`CPU_REG_COUNT-1];

    // Written on the rising edge and never for r0
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads with r0 hardwired to zero
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// ==== verilog/control_unit.sv ====
// Purely combinational instruction decoder
// Turns one instruction word into the controls latched by the ID/EX register
`include "cpu_params.svh"

module control_unit
    import cpu_pkg::*;
(
    input  word_t     inst,
    output alu_op_e   alu_op,
    output logic      a_from_rt,
    output logic      b_from_imm,
    output word_t     imm_word,
    output reg_addr_t rf_waddr,
    output logic      rf_wen,
    output logic      wb_from_mem,
    output logic      dm_wen,
    output logic      syscall,
    output logic      ovf_check
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] shamt;
    reg_addr_t  rt;
    reg_addr_t  rd;
    imm_t       imm;
    logic       dest_is_rd;
    logic       writes_reg;

    // Instruction fields
    assign opcode = inst[31:26];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign shamt  = inst[10:6];
    assign funct  = inst[5:0];
    assign imm    = inst[15:0];

    always_comb begin
        // Default is a no-op that also covers unknown codes
        alu_op      = ALU_ADD;
        a_from_rt   = 1'b0;
        b_from_imm  = 1'b0;
        imm_word    = {{(`CPU_WORD_W-16){1'b0}}, imm};
        dest_is_rd  = 1'b0;
        writes_reg  = 1'b0;
        wb_from_mem = 1'b0;
        dm_wen      = 1'b0;
        syscall     = 1'b0;
        ovf_check   = 1'b0;
        case (opcode)
            `CPU_OP_RTYPE: begin
                dest_is_rd = 1'b1;
                writes_reg = 1'b1;
                case (funct)
                    `CPU_FN_ADD: begin
                        alu_op    = ALU_ADD;
                        ovf_check = 1'b1;
                    end
                    `CPU_FN_SUB: begin
                        alu_op    = ALU_SUB;
                        ovf_check = 1'b1;
                    end
                    `CPU_FN_AND: alu_op = ALU_AND;
                    `CPU_FN_OR:  alu_op = ALU_OR;
                    `CPU_FN_XOR: alu_op = ALU_XOR;
                    `CPU_FN_SLT: alu_op = ALU_SLT;
                    `CPU_FN_SLL, `CPU_FN_SRL: begin
                        // Shift rt by shamt carried on the immediate path
                        alu_op     = (funct == `CPU_FN_SLL) ? ALU_SLL : ALU_SRL;
                        a_from_rt  = 1'b1;
                        b_from_imm = 1'b1;
                        imm_word   = {{(`CPU_WORD_W-5){1'b0}}, shamt};
                    end
                    `CPU_FN_SYSCALL: begin
                        writes_reg = 1'b0;
                        syscall    = 1'b1;
                    end
                    default: writes_reg = 1'b0;
                endcase
            end
            `CPU_OP_ADDI: begin
                b_from_imm = 1'b1;
                writes_reg = 1'b1;
                ovf_check  = 1'b1;
                imm_word   = {{(`CPU_WORD_W-16){imm[15]}}, imm};
            end
            `CPU_OP_ANDI, `CPU_OP_ORI: begin
                // Zero-extended immediate from the default
                alu_op     = (opcode == `CPU_OP_ANDI) ? ALU_AND : ALU_OR;
                b_from_imm = 1'b1;
                writes_reg = 1'b1;
            end
            `CPU_OP_LUI: begin
                alu_op     = ALU_LUI;
                b_from_imm = 1'b1;
                writes_reg = 1'b1;
            end
            `CPU_OP_LW, `CPU_OP_SW: begin
                // Address is rs plus sign-extended offset
                b_from_imm  = 1'b1;
                imm_word    = {{(`CPU_WORD_W-16){imm[15]}}, imm};
                writes_reg  = (opcode == `CPU_OP_LW);
                wb_from_mem = (opcode == `CPU_OP_LW);
                dm_wen      = (opcode == `CPU_OP_SW);
            end
            default: ;
        endcase
    end

    // Destination select that drops writes to r0
    assign rf_waddr = dest_is_rd ? rd : rt;
    assign rf_wen   = writes_reg && (rf_waddr != '0);

endmodule

// ==== verilog/cpu_pkg.sv ====
// Common types of the pipeline core
// Modules pull these in by a wildcard import in their header
`include "cpu_params.svh"

package cpu_pkg;

    // ========================================
    // Vector types
    // ========================================

    // Data and instruction word
    typedef logic [`CPU_WORD_W-1:0] word_t;

    // Register index of the rs, rt and rd fields
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

    // Raw immediate field of I-type words
    typedef logic [15:0] imm_t;

    // Word index into data memory
    typedef logic [`CPU_DMEM_INDEX_W-1:0] dmem_index_t;

    // ========================================
    // ALU operation
    // ========================================

    // ALU_ADD first so a cleared pipeline register decodes as add
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

endpackage

// ==== verilog/cpu_params.svh ====
// Shared widths, sizes and instruction encodings for the pipeline core
// Include wherever a width or an opcode/funct code is needed
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths and sizes
`define CPU_WORD_W          32
`define CPU_REG_ADDR_W      5
`define CPU_REG_COUNT       32
`define CPU_DMEM_WORDS      64
`define CPU_DMEM_INDEX_W    6

// Opcodes in bits 31..26
`define CPU_OP_RTYPE        6'h00
`define CPU_OP_ADDI         6'h08
`define CPU_OP_ANDI         6'h0c
`define CPU_OP_ORI          6'h0d
`define CPU_OP_LUI          6'h0f
`define CPU_OP_LW           6'h23
`define CPU_OP_SW           6'h2b

// R-type funct codes in bits 5..0
`define CPU_FN_SLL          6'h00
`define CPU_FN_SRL          6'h02
`define CPU_FN_SYSCALL      6'h0c
`define CPU_FN_ADD          6'h20
`define CPU_FN_SUB          6'h22
`define CPU_FN_AND          6'h24
`define CPU_FN_OR           6'h25
`define CPU_FN_XOR          6'h26
`define CPU_FN_SLT          6'h2a

`endif
